//--- bench/cpu_tb.sv
module cpu_tb;

  localparam int RST_CYCLES = 10;
  localparam int CLK_PERIOD = 4;
  localparam int RUN_LIMIT  = 400;   // instructions per run with headroom
  localparam int TIMEOUT    = 2 * RUN_LIMIT * CLK_PERIOD + 2 * RST_CYCLES * CLK_PERIOD;

  logic                          clk;
  logic                          rst;
  logic                          done;
  logic                          reg_wr_en;
  logic [cpu_pkg::REG_AW-1:0]    reg_wr_addr;
  logic [cpu_pkg::DATA_W-1:0]    reg_wr_data;
  logic                          mem_wr_en;
  logic [cpu_pkg::MEM_AW-1:0]    mem_addr;
  logic [cpu_pkg::DATA_W-1:0]    mem_wr_data;
  logic [cpu_pkg::PC_W-1:0]      pc;

  tb_clock clk_gen (.clk(clk));

  cpu_top cpu_top_inst (
    .clk         (clk),
    .rst         (rst),
    .done        (done),
    .reg_wr_en   (reg_wr_en),
    .reg_wr_addr (reg_wr_addr),
    .reg_wr_data (reg_wr_data),
    .mem_wr_en   (mem_wr_en),
    .mem_addr    (mem_addr),
    .mem_wr_data (mem_wr_data),
    .pc          (pc)
  );

  // ISA model state
  logic [cpu_pkg::INSTR_W-1:0] prog [0:cpu_pkg::ROM_DEPTH-1];
  logic [cpu_pkg::DATA_W-1:0]  m_regs [0:cpu_pkg::REG_CNT-1];
  logic [cpu_pkg::DATA_W-1:0]  m_mem [0:cpu_pkg::MEM_DEPTH-1];
  logic [cpu_pkg::PC_W-1:0]    m_pc;
  logic                        m_c;
  logic                        m_p;
  logic                        m_done_q;
  logic                        armed = 1'b0;   // set once pc is known
  int                          halts = 0;

  // what the current instruction should do
  logic [cpu_pkg::PC_W-1:0]    nxt_pc;
  logic                        nxt_c;
  logic                        nxt_p;
  logic                        exp_reg_en;
  logic [cpu_pkg::REG_AW-1:0]  exp_reg_addr;
  logic [cpu_pkg::DATA_W-1:0]  exp_reg_data;
  logic                        exp_mem_en;
  logic [cpu_pkg::MEM_AW-1:0]  exp_mem_addr;
  logic [cpu_pkg::DATA_W-1:0]  exp_mem_data;
  logic                        exp_done;
  logic                        is_shift;
  logic                        is_load;

  initial begin
    $readmemb("design/program.mem", prog);
  end

  always_comb begin : model_comb
    cpu_pkg::opcode_e            opc;
    logic [cpu_pkg::OPND_W-1:0]  opnd;
    logic [cpu_pkg::DATA_W-1:0]  a;
    logic [cpu_pkg::DATA_W-1:0]  b;
    int                          sum;
    opc  = cpu_pkg::opcode_e'(prog[m_pc][8:5]);
    opnd = prog[m_pc][4:0];
    a    = m_regs[0];
    b    = m_regs[opnd[3:0]];
    sum  = 0;
    nxt_pc       = m_pc + 1'b1;
    nxt_c        = m_c;
    nxt_p        = m_p;
    exp_reg_en   = 1'b0;
    exp_reg_addr = '0;
    exp_reg_data = a;
    exp_mem_en   = 1'b0;
    exp_mem_addr = cpu_pkg::ADDR_LUT[opnd];
    exp_mem_data = a;
    exp_done     = 1'b0;
    is_shift     = (opc == cpu_pkg::op_shl) || (opc == cpu_pkg::op_shr);
    is_load      = (opc == cpu_pkg::op_ld);
    case (opc)
      cpu_pkg::op_add: begin
        sum          = a + b;
        exp_reg_data = sum[7:0];
        nxt_c        = (sum > 255);
        exp_reg_en   = 1'b1;
      end
      cpu_pkg::op_adc: begin
        sum          = a + b + m_c;
        exp_reg_data = sum[7:0];
        nxt_c        = (sum > 255);
        exp_reg_en   = 1'b1;
      end
      cpu_pkg::op_sub: begin
        exp_reg_data = a - b;
        nxt_c        = (a < b);   // borrow
        exp_reg_en   = 1'b1;
      end
      cpu_pkg::op_xor: begin
        exp_reg_data = a ^ b;
        exp_reg_en   = 1'b1;
      end
      cpu_pkg::op_shl: begin
        exp_reg_data = (a << 1) | 8'(m_c);
        nxt_c        = a[7];
        exp_reg_en   = 1'b1;
      end
      cpu_pkg::op_shr: begin
        exp_reg_data = (a >> 1) | (8'(m_c) << 7);
        nxt_c        = a[0];
        exp_reg_en   = 1'b1;
      end
      cpu_pkg::op_ldi: begin
        exp_reg_data = cpu_pkg::CONST_LUT[opnd];
        exp_reg_en   = 1'b1;
      end
      cpu_pkg::op_get: begin
        exp_reg_data = b;
        exp_reg_en   = 1'b1;
      end
      cpu_pkg::op_put: begin
        exp_reg_addr = opnd[3:0];
        exp_reg_en   = 1'b1;
      end
      cpu_pkg::op_ld: begin
        exp_reg_data = m_mem[cpu_pkg::ADDR_LUT[opnd]];
        exp_reg_en   = 1'b1;
      end
      cpu_pkg::op_st:  exp_mem_en = 1'b1;
      cpu_pkg::op_par: nxt_p = m_p ^ (^a);
      cpu_pkg::op_clf: begin
        nxt_c = 1'b0;
        nxt_p = 1'b0;
      end
      cpu_pkg::op_jz: if (a == 0) nxt_pc = cpu_pkg::BRANCH_LUT[opnd[3:0]];
      cpu_pkg::op_jp: if (m_p) nxt_pc = cpu_pkg::BRANCH_LUT[opnd[3:0]];
      default: begin              // halt
        nxt_pc   = m_pc;
        exp_done = 1'b1;
      end
    endcase
  end

  // model commits on the same edge as the DUT
  always @(posedge clk) begin
    armed <= 1'b1;
    if (rst) begin
      m_pc     <= '0;
      m_c      <= 1'b0;
      m_p      <= 1'b0;
      m_done_q <= 1'b0;
      for (int i = 0; i < cpu_pkg::REG_CNT; i++) begin
        m_regs[i] <= '0;
      end
    end else begin
      m_pc     <= nxt_pc;
      m_c      <= nxt_c;
      m_p      <= nxt_p;
      m_done_q <= exp_done;
      if (exp_reg_en) m_regs[exp_reg_addr] <= exp_reg_data;
      if (exp_mem_en) m_mem[exp_mem_addr] <= exp_mem_data;
      if (exp_done && !m_done_q) halts <= halts + 1;   // first halt cycle of a run
    end
  end

  task automatic report_mismatch(input string name, input int unsigned expv,
                                 input int unsigned actv);
    $display("Mismatch in %s: expected %0h, actual %0h", name, expv, actv);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_failure(input string msg);
    $display("Error: %s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run aborted");
  endtask

  a_pc: assert property (@(posedge clk) armed |-> pc == m_pc)
    else report_mismatch("control flow pc", $sampled(m_pc), $sampled(pc));
  a_done: assert property (@(posedge clk) armed |-> done == exp_done)
    else report_mismatch("halt done", $sampled(exp_done), $sampled(done));
  a_reg_en: assert property (@(posedge clk) !rst |-> reg_wr_en == exp_reg_en)
    else report_mismatch("register write enable", $sampled(exp_reg_en), $sampled(reg_wr_en));
  a_reg_addr: assert property (@(posedge clk) (!rst && exp_reg_en) |-> reg_wr_addr == exp_reg_addr)
    else report_mismatch("register write address", $sampled(exp_reg_addr),
                         $sampled(reg_wr_addr));
  a_arith: assert property (@(posedge clk)
      (!rst && exp_reg_en && !is_shift && !is_load) |-> reg_wr_data == exp_reg_data)
    else report_mismatch("arithmetic writeback", $sampled(exp_reg_data), $sampled(reg_wr_data));
  a_shift: assert property (@(posedge clk)
      (!rst && exp_reg_en && is_shift) |-> reg_wr_data == exp_reg_data)
    else report_mismatch("shift writeback", $sampled(exp_reg_data), $sampled(reg_wr_data));
  a_load: assert property (@(posedge clk)
      (!rst && exp_reg_en && is_load) |-> reg_wr_data == exp_reg_data)
    else report_mismatch("memory load", $sampled(exp_reg_data), $sampled(reg_wr_data));
  a_mem_en: assert property (@(posedge clk) !rst |-> mem_wr_en == exp_mem_en)
    else report_mismatch("memory write enable", $sampled(exp_mem_en), $sampled(mem_wr_en));
  a_mem_addr: assert property (@(posedge clk) (!rst && exp_mem_en) |-> mem_addr == exp_mem_addr)
    else report_mismatch("memory store address", $sampled(exp_mem_addr), $sampled(mem_addr));
  a_mem_data: assert property (@(posedge clk) (!rst && exp_mem_en) |-> mem_wr_data == exp_mem_data)
    else report_mismatch("memory store data", $sampled(exp_mem_data), $sampled(mem_wr_data));
  a_rst_reg: assert property (@(posedge clk) rst |-> !reg_wr_en)
    else report_mismatch("reset register strobe", 0, $sampled(reg_wr_en));
  a_rst_mem: assert property (@(posedge clk) rst |-> !mem_wr_en)
    else report_mismatch("reset memory strobe", 0, $sampled(mem_wr_en));

  task automatic wait_for_done();
    @(negedge clk);
    while (!done) @(negedge clk);
  endtask

  initial begin : stimulus
    integer seed;
    int     gap;
    seed = 84404;
    rst  = 1'b1;
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    wait_for_done();
    gap = 1 + ($unsigned($random(seed)) % 8);   // reset lands a few cycles into halt
    repeat (gap) @(negedge clk);
    rst = 1'b1;
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    wait_for_done();
    repeat (4) @(negedge clk);
    if (halts == 2) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      report_failure($sformatf("model reached halt %0d times instead of 2", halts));
    end
  end

  initial begin : watchdog
    #(TIMEOUT);
    report_failure("watchdog expired before both runs reached halt");
  end

endmodule

//--- bench/tb_clock.sv
module tb_clock (
  output logic clk
);

  localparam int HALF_PERIOD = 2;   // full period 4

  initial begin
    clk = 1'b0;
  end

  always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- design/cpu_ifs.sv
// decoded instruction and its operands, decode -> execute
interface exec_if;
  cpu_pkg::opcode_e                  op;
  logic [cpu_pkg::OPND_W-1:0]        operand;
  logic [cpu_pkg::DATA_W-1:0]        acc;      // r0
  logic [cpu_pkg::DATA_W-1:0]        src;      // rN
  logic [cpu_pkg::REG_AW-1:0]        dst;

  modport dec (
    output op, operand, acc, src, dst
  );

  modport exec (
    input op, operand, acc, src, dst
  );
endinterface

// ALU result and memory request, execute -> memory
interface mem_if;
  logic [cpu_pkg::OPND_W-1:0]        operand;  // index into ADDR_LUT
  logic [cpu_pkg::DATA_W-1:0]        result;
  logic                              wr_reg;
  logic [cpu_pkg::REG_AW-1:0]        dst;
  logic                              load;
  logic                              store;
  logic [cpu_pkg::DATA_W-1:0]        store_data;

  modport alu (
    output operand, result, wr_reg, dst, load, store, store_data
  );

  modport mem (
    input operand, result, wr_reg, dst, load, store, store_data
  );
endinterface

//--- design/cpu_pkg.sv
package cpu_pkg;

  localparam int INSTR_W   = 9;
  localparam int OPC_W     = 4;      // opcode field, top of the instruction
  localparam int OPND_W    = 5;      // operand field, bottom of the instruction
  localparam int DATA_W    = 8;
  localparam int PC_W      = 10;
  localparam int ROM_DEPTH = 1024;
  localparam int REG_CNT   = 16;
  localparam int REG_AW    = 4;      // register index width
  localparam int MEM_DEPTH = 256;
  localparam int MEM_AW    = 8;
  localparam int LUT_DEPTH = 32;     // one entry per operand value
  localparam int BR_DEPTH  = 16;

  typedef enum logic [OPC_W-1:0] {
    op_add  = 4'h0,
    op_adc  = 4'h1,
    op_sub  = 4'h2,
    op_xor  = 4'h3,
    op_shl  = 4'h4,
    op_shr  = 4'h5,
    op_ldi  = 4'h6,
    op_get  = 4'h7,
    op_put  = 4'h8,
    op_ld   = 4'h9,
    op_st   = 4'ha,
    op_par  = 4'hb,
    op_clf  = 4'hc,
    op_jz   = 4'hd,
    op_jp   = 4'he,
    op_halt = 4'hf
  } opcode_e;

  // constants for op_ldi
  localparam logic [DATA_W-1:0] CONST_LUT [0:LUT_DEPTH-1] = '{
    8'h00, 8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h07, 8'h08,
    8'h0f, 8'h10, 8'h20, 8'h3c, 8'h40, 8'h55, 8'h7f, 8'h80,
    8'haa, 8'hc3, 8'hf0, 8'hfe, 8'hff, 8'h12, 8'h34, 8'h5a,
    8'h69, 8'h96, 8'ha5, 8'h0a, 8'h64, 8'h33, 8'h81, 8'h06
  };

  // data memory addresses for op_ld / op_st
  localparam logic [MEM_AW-1:0] ADDR_LUT [0:LUT_DEPTH-1] = '{
    8'h00, 8'h01, 8'h02, 8'h03, 8'h04, 8'h08, 8'h10, 8'h20,
    8'h40, 8'h7f, 8'h80, 8'ha0, 8'hc0, 8'he0, 8'hfe, 8'hff,
    8'h05, 8'h06, 8'h07, 8'h09, 8'h0a, 8'h0b, 8'h0c, 8'h0d,
    8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 8'h66, 8'h77, 8'h88
  };

  // absolute jump targets, indexed by operand[3:0]
  localparam logic [PC_W-1:0] BRANCH_LUT [0:BR_DEPTH-1] = '{
    10'd0,  10'd2,  10'd4,  10'd6,  10'd8,  10'd10, 10'd12, 10'd14,
    10'd16, 10'd18, 10'd20, 10'd22, 10'd24, 10'd26, 10'd28, 10'd30
  };

endpackage

//--- design/cpu_top.sv
module cpu_top (
  input  logic                          clk,
  input  logic                          rst,
  output logic                          done,
  output logic                          reg_wr_en,
  output logic [cpu_pkg::REG_AW-1:0]    reg_wr_addr,
  output logic [cpu_pkg::DATA_W-1:0]    reg_wr_data,
  output logic                          mem_wr_en,
  output logic [cpu_pkg::MEM_AW-1:0]    mem_addr,
  output logic [cpu_pkg::DATA_W-1:0]    mem_wr_data,
  output logic [cpu_pkg::PC_W-1:0]      pc
);

  logic [cpu_pkg::INSTR_W-1:0] instr;
  logic                        branch_taken;
  logic [3:0]                  branch_sel;

  exec_if ex_bus ();
  mem_if  mem_bus ();

  fetch_stage fetch_inst (
    .clk          (clk),
    .rst          (rst),
    .branch_taken (branch_taken),
    .branch_sel   (branch_sel),
    .instr        (instr),
    .pc           (pc),
    .done         (done)
  );

  // register file write port is fed back from writeback
  decode_stage decode_inst (
    .clk         (clk),
    .rst         (rst),
    .instr       (instr),
    .reg_wr_en   (reg_wr_en),
    .reg_wr_addr (reg_wr_addr),
    .reg_wr_data (reg_wr_data),
    .ex          (ex_bus.dec)
  );

  execute_stage execute_inst (
    .clk          (clk),
    .rst          (rst),
    .ex           (ex_bus.exec),
    .mo           (mem_bus.alu),
    .branch_taken (branch_taken),
    .branch_sel   (branch_sel)
  );

  memory_stage memory_inst (
    .clk         (clk),
    .mo          (mem_bus.mem),
    .reg_wr_en   (reg_wr_en),
    .reg_wr_addr (reg_wr_addr),
    .reg_wr_data (reg_wr_data),
    .mem_wr_en   (mem_wr_en),
    .mem_addr    (mem_addr),
    .mem_wr_data (mem_wr_data)
  );

endmodule

//--- design/decode_stage.sv
module decode_stage (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [cpu_pkg::INSTR_W-1:0]    instr,
  input  logic                           reg_wr_en,
  input  logic [cpu_pkg::REG_AW-1:0]     reg_wr_addr,
  input  logic [cpu_pkg::DATA_W-1:0]     reg_wr_data,
  exec_if.dec                            ex
);

  cpu_pkg::opcode_e              opc;
  logic [cpu_pkg::OPND_W-1:0]    operand;
  logic [cpu_pkg::REG_AW-1:0]    rn;
  logic [cpu_pkg::DATA_W-1:0]    r0_val;
  logic [cpu_pkg::DATA_W-1:0]    rn_val;

  // field split
  assign opc     = cpu_pkg::opcode_e'(instr[cpu_pkg::INSTR_W-1 -: cpu_pkg::OPC_W]);
  assign operand = instr[cpu_pkg::OPND_W-1:0];
  assign rn      = operand[cpu_pkg::REG_AW-1:0];

  // port a always reads the accumulator
  reg_file reg_file_inst (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (reg_wr_en),
    .wr_addr   (reg_wr_addr),
    .wr_data   (reg_wr_data),
    .rd_addr_a ('0),
    .rd_addr_b (rn),
    .rd_data_a (r0_val),
    .rd_data_b (rn_val)
  );

  assign ex.op      = opc;
  assign ex.operand = operand;
  assign ex.acc     = r0_val;
  assign ex.src     = rn_val;

  // only put targets rN, everything else lands in r0
  always_comb begin
    if (opc == cpu_pkg::op_put) begin
      ex.dst = rn;
    end else begin
      ex.dst = '0;
    end
  end

endmodule

//--- design/execute_stage.sv
module execute_stage (
  input  logic         clk,
  input  logic         rst,
  exec_if.exec         ex,
  mem_if.alu           mo,
  output logic         branch_taken,
  output logic [3:0]   branch_sel
);

  logic [cpu_pkg::DATA_W-1:0]  rslt;
  logic [cpu_pkg::DATA_W:0]    wide;     // result with carry/borrow on top
  logic                        wr_reg_c;
  logic                        load_c;
  logic                        store_c;

  // flag registers and their controls
  logic sc_q, sc_o, sc_en, sc_clr;
  logic par_q, par_d, par_en, par_clr;

  always_comb begin
    rslt     = ex.acc;
    wide     = '0;
    wr_reg_c = 1'b0;
    load_c   = 1'b0;
    store_c  = 1'b0;
    sc_o     = sc_q;
    sc_en    = 1'b0;
    sc_clr   = 1'b0;
    par_d    = par_q;
    par_en   = 1'b0;
    par_clr  = 1'b0;
    case (ex.op)
      cpu_pkg::op_add: begin
        wide     = {1'b0, ex.acc} + {1'b0, ex.src};
        rslt     = wide[cpu_pkg::DATA_W-1:0];
        sc_o     = wide[cpu_pkg::DATA_W];
        sc_en    = 1'b1;
        wr_reg_c = 1'b1;
      end
      cpu_pkg::op_adc: begin
        wide     = {1'b0, ex.acc} + {1'b0, ex.src} + {{cpu_pkg::DATA_W{1'b0}}, sc_q};
        rslt     = wide[cpu_pkg::DATA_W-1:0];
        sc_o     = wide[cpu_pkg::DATA_W];
        sc_en    = 1'b1;
        wr_reg_c = 1'b1;
      end
      cpu_pkg::op_sub: begin
        wide     = {1'b0, ex.acc} - {1'b0, ex.src};
        rslt     = wide[cpu_pkg::DATA_W-1:0];
        sc_o     = wide[cpu_pkg::DATA_W];   // borrow
        sc_en    = 1'b1;
        wr_reg_c = 1'b1;
      end
      cpu_pkg::op_xor: begin
        rslt     = ex.acc ^ ex.src;
        wr_reg_c = 1'b1;
      end
      cpu_pkg::op_shl: begin
        rslt     = {ex.acc[cpu_pkg::DATA_W-2:0], sc_q};
        sc_o     = ex.acc[cpu_pkg::DATA_W-1];
        sc_en    = 1'b1;
        wr_reg_c = 1'b1;
      end
      cpu_pkg::op_shr: begin
        rslt     = {sc_q, ex.acc[cpu_pkg::DATA_W-1:1]};
        sc_o     = ex.acc[0];
        sc_en    = 1'b1;
        wr_reg_c = 1'b1;
      end
      cpu_pkg::op_ldi: begin
        rslt     = cpu_pkg::CONST_LUT[ex.operand];
        wr_reg_c = 1'b1;
      end
      cpu_pkg::op_get: begin
        rslt     = ex.src;
        wr_reg_c = 1'b1;
      end
      cpu_pkg::op_put: wr_reg_c = 1'b1;   // r0 passes through to rN
      cpu_pkg::op_ld: begin
        load_c   = 1'b1;
        wr_reg_c = 1'b1;
      end
      cpu_pkg::op_st: store_c = 1'b1;
      cpu_pkg::op_par: begin
        par_d  = par_q ^ (^ex.acc);       // accumulate parity of r0
        par_en = 1'b1;
      end
      cpu_pkg::op_clf: begin
        sc_clr  = 1'b1;
        par_clr = 1'b1;
      end
      default: ;                          // jz, jp, halt write nothing
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst || sc_clr) begin
      sc_q <= 1'b0;
    end else if (sc_en) begin
      sc_q <= sc_o;
    end
    if (rst || par_clr) begin
      par_q <= 1'b0;
    end else if (par_en) begin
      par_q <= par_d;
    end
  end

  // branch decision, target lookup happens in fetch
  always_comb begin
    case (ex.op)
      cpu_pkg::op_jz: branch_taken = (ex.acc == '0);
      cpu_pkg::op_jp: branch_taken = par_q;
      default:        branch_taken = 1'b0;
    endcase
  end
  assign branch_sel = ex.operand[3:0];

  assign mo.operand    = ex.operand;
  assign mo.result     = rslt;
  assign mo.dst        = ex.dst;
  assign mo.load       = load_c;
  assign mo.store_data = ex.acc;
  assign mo.wr_reg     = wr_reg_c & ~rst;   // no commits while in reset
  assign mo.store      = store_c & ~rst;

endmodule

//--- design/fetch_stage.sv
module fetch_stage (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           branch_taken,
  input  logic [3:0]                     branch_sel,
  output logic [cpu_pkg::INSTR_W-1:0]    instr,
  output logic [cpu_pkg::PC_W-1:0]       pc,
  output logic                           done
);

  logic [cpu_pkg::INSTR_W-1:0] rom [0:cpu_pkg::ROM_DEPTH-1];
  logic [cpu_pkg::PC_W-1:0]    pc_q;
  logic [cpu_pkg::PC_W-1:0]    pc_next;
  cpu_pkg::opcode_e            opc;
  logic                        halted;

  initial begin
    $readmemb("design/program.mem", rom);
  end

  assign instr  = rom[pc_q];   // async ROM read
  assign opc    = cpu_pkg::opcode_e'(instr[cpu_pkg::INSTR_W-1 -: cpu_pkg::OPC_W]);
  assign halted = (opc == cpu_pkg::op_halt);

  // hold on halt, otherwise jump or step
  always_comb begin
    if (halted) begin
      pc_next = pc_q;
    end else if (branch_taken) begin
      pc_next = cpu_pkg::BRANCH_LUT[branch_sel];
    end else begin
      pc_next = pc_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign pc   = pc_q;
  assign done = halted;   // pc holds, so this stays up until reset

endmodule

//--- design/memory_stage.sv
module memory_stage (
  input  logic                          clk,
  mem_if.mem                            mo,
  output logic                          reg_wr_en,
  output logic [cpu_pkg::REG_AW-1:0]    reg_wr_addr,
  output logic [cpu_pkg::DATA_W-1:0]    reg_wr_data,
  output logic                          mem_wr_en,
  output logic [cpu_pkg::MEM_AW-1:0]    mem_addr,
  output logic [cpu_pkg::DATA_W-1:0]    mem_wr_data
);

  logic [cpu_pkg::DATA_W-1:0] dmem [0:cpu_pkg::MEM_DEPTH-1];
  logic [cpu_pkg::MEM_AW-1:0] addr;
  logic [cpu_pkg::DATA_W-1:0] rd_data;

  assign addr    = cpu_pkg::ADDR_LUT[mo.operand];
  assign rd_data = dmem[addr];   // async read

  always_ff @(posedge clk) begin
    if (mo.store) begin
      dmem[addr] <= mo.store_data;
    end
  end

  // writeback select
  always_comb begin
    if (mo.load) begin
      reg_wr_data = rd_data;
    end else begin
      reg_wr_data = mo.result;
    end
  end

  assign reg_wr_en   = mo.wr_reg;
  assign reg_wr_addr = mo.dst;
  assign mem_wr_en   = mo.store;
  assign mem_addr    = addr;
  assign mem_wr_data = mo.store_data;

endmodule

//--- design/program.mem
// opcode[8:5] operand[4:0], binary, one instruction per line from address 0
// branch targets sit at even addresses (BRANCH_LUT entry n is 2n)
011010100 // 0: ldi ff
100000001 // 1: put r1
011000001 // 2: ldi 01
000000001 // 3: add r1, wraps to 00 with carry
000100001 // 4: adc r1, carry chain
100000010 // 5: put r2
011010001 // 6: ldi c3
010000000 // 7: shl, carry in and out
010100000 // 8: shr
101000101 // 9: st to 08
110000000 // 10: clf
011000011 // 11: ldi 03
100000011 // 12: put r3, loop count
011000001 // 13: ldi 01
100000100 // 14: put r4, decrement
001000001 // 15: sub r1 with borrow
011100011 // 16: get r3, loop top
001000100 // 17: sub r4
100000011 // 18: put r3
110101011 // 19: jz to 22 when count hits zero
011000000 // 20: ldi 00
110101000 // 21: jz to 16, always taken
100100101 // 22: ld from 08
101100000 // 23: par, even
111001110 // 24: jp to 28, not taken
011000110 // 25: ldi 07
101100000 // 26: par, odd
111001111 // 27: jp to 30, taken
111100000 // 28: halt, skipped
111100000 // 29: halt, skipped
101000110 // 30: st to 10
100100110 // 31: ld from 10
001100001 // 32: xor r1
111100000 // 33: halt

//--- design/reg_file.sv
module reg_file (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          wr_en,
  input  logic [cpu_pkg::REG_AW-1:0]    wr_addr,
  input  logic [cpu_pkg::DATA_W-1:0]    wr_data,
  input  logic [cpu_pkg::REG_AW-1:0]    rd_addr_a,
  input  logic [cpu_pkg::REG_AW-1:0]    rd_addr_b,
  output logic [cpu_pkg::DATA_W-1:0]    rd_data_a,
  output logic [cpu_pkg::DATA_W-1:0]    rd_data_b
);

  logic [cpu_pkg::DATA_W-1:0] regs [0:cpu_pkg::REG_CNT-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < cpu_pkg::REG_CNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];

endmodule

//--- tb.f
design/cpu_pkg.sv
design/cpu_ifs.sv
design/reg_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/cpu_top.sv
bench/tb_clock.sv
bench/cpu_tb.sv
